/* list.f */
src/dcest_cfg_pkg.sv
src/dcest_data_pkg.sv
src/sample_ram.sv
src/ram_arbiter.sv
src/sample_loader.sv
src/frame_reader.sv
src/dc_estimator.sv
src/dcest_top.sv
dv/dcest_assert.sv
dv/dcest_tb.sv

/* dv/dcest_tb.sv */
module dcest_tb
  import dcest_cfg_pkg::*;
  import dcest_data_pkg::*;
();

  localparam int NUM_TESTS = 7;

  typedef enum logic [1:0] {
    KIND_RANDOM,
    KIND_CONST,
    KIND_EXTREME
  } data_kind_t;

  // one row of the test table
  typedef struct packed {
    dcest_cfg_t cfg;
    data_kind_t kind;
  } test_row_t;

  logic       clk;
  logic       rst_n;
  logic       ld_req;
  ram_word_t  ld_word;
  logic       ld_ack;
  logic       run_req;
  dcest_cfg_t cfg;
  logic       run_ack;
  result_t    dut_result;

  test_row_t  tests [NUM_TESTS];
  ram_word_t  block_words [256];
  logic [31:0] rng_state = 32'd99;
  int         error_count = 0;
  int         fail_count = 0;
  int         cycle_count = 0;
  int         cycle_limit = 0;

  dcest_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_ld_req (ld_req),
    .i_ld_word(ld_word),
    .o_ld_ack (ld_ack),
    .i_run_req(run_req),
    .i_cfg    (cfg),
    .o_run_ack(run_ack),
    .o_result (dut_result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run hung after %0d cycles", cycle_count);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // failures flagged so far by the bound checkers
  function automatic int assertion_failures();
    return DUT.u_arbiter.u_arb_assert.fail_count + DUT.u_estimator.u_est_assert.fail_count;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus data and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_block(input data_kind_t kind, input int nwords);
    for (int w = 0; w < nwords; w++) begin
      for (int k = 0; k < LANES; k++) begin
        if (kind == KIND_RANDOM) begin
          rng_state = next_random(rng_state);
          block_words[w][k*16 +: 16] = rng_state[23:8];
        end else if (kind == KIND_CONST) begin
          // I and Q differ in sign so a swapped field shows up
          block_words[w][k*16 +: 16] = (k % 2 == 0) ? 16'sd12000 : -16'sd7000;
        end else begin
          block_words[w][k*16 +: 16] = 16'h8000;
        end
      end
    end
  endtask

  function automatic result_t expected_result(input dcest_cfg_t c, input int nwords);
    logic signed [63:0] sum_i;
    logic signed [63:0] sum_q;
    logic signed [63:0] gain;
    logic signed [63:0] sh_i;
    logic signed [63:0] sh_q;
    iq_t                lane;
    sum_i = 0;
    sum_q = 0;
    gain  = {47'b0, c.scale};
    for (int w = 0; w < nwords; w++) begin
      for (int k = 0; k < LANES; k++) begin
        lane = block_words[w][k*16 +: 16];
        if (k % 2 == 0) begin
          sum_i = sum_i + lane;
        end else begin
          sum_q = sum_q + lane;
        end
      end
    end
    if (c.mode == EST_REAL) begin
      sh_i = ((sum_i + sum_q) * gain) >>> 24;
      return sh_i[31:0];
    end
    sh_i = (sum_i * gain) >>> 24;
    sh_q = (sum_q * gain) >>> 24;
    return {sh_q[63], sh_q[14:0], sh_i[63], sh_i[14:0]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // host side handshakes
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_word(input ram_word_t w);
    @(posedge clk);
    ld_word <= w;
    ld_req  <= 1'b1;
    do @(negedge clk); while (ld_ack !== 1'b1);
    // ack must hold while the request is still high
    @(negedge clk);
    assert (ld_ack === 1'b1) else begin
      $display("load ack dropped before the request was released");
      error_count++;
    end
    @(posedge clk);
    ld_req <= 1'b0;
    do @(negedge clk); while (ld_ack !== 1'b0);
  endtask

  task automatic run_block(input dcest_cfg_t c, output result_t got);
    @(posedge clk);
    cfg     <= c;
    run_req <= 1'b1;
    do @(negedge clk); while (run_ack !== 1'b1);
    got = dut_result;
    // ack and result must hold while the request is still high
    @(negedge clk);
    assert (run_ack === 1'b1 && dut_result === got) else begin
      $display("run ack or result changed before the request was released");
      error_count++;
    end
    @(posedge clk);
    run_req <= 1'b0;
    do @(negedge clk); while (run_ack !== 1'b0);
  endtask

  initial begin
    int      nwords;
    int      total_words;
    int      errors_before;
    int      test_errors;
    int      total_errors;
    string   mode_name;
    result_t exp;
    result_t got;

    ld_req  <= 1'b0;
    ld_word <= '0;
    run_req <= 1'b0;
    cfg     <= '0;
    rst_n   <= 1'b0;

    tests[0] = '{cfg: '{EST_COMPLEX, 4'd3, 4'd1, 17'h10000}, kind: KIND_CONST};
    tests[1] = '{cfg: '{EST_REAL, 4'd7, 4'd3, 17'h0C000}, kind: KIND_RANDOM};
    tests[2] = '{cfg: '{EST_COMPLEX, 4'd15, 4'd15, 17'h1FFFF}, kind: KIND_EXTREME};
    tests[3] = '{cfg: '{EST_REAL, 4'd0, 4'd0, 17'h1FFFF}, kind: KIND_EXTREME};
    tests[4] = '{cfg: '{EST_COMPLEX, 4'd5, 4'd2, 17'h08000}, kind: KIND_RANDOM};
    tests[5] = '{cfg: '{EST_REAL, 4'd15, 4'd15, 17'h10000}, kind: KIND_RANDOM};
    tests[6] = '{cfg: '{EST_COMPLEX, 4'd0, 4'd0, 17'h1FFFF}, kind: KIND_RANDOM};

    // each word needs a load and a read, about 12 cycles each at most
    total_words = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_words += (tests[t].cfg.smp_cnt + 1) * (tests[t].cfg.chp_cnt + 1);
    end
    cycle_limit = 2 * total_words * 12 + 200;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) begin
      errors_before = error_count + assertion_failures();
      nwords = (tests[t].cfg.smp_cnt + 1) * (tests[t].cfg.chp_cnt + 1);
      fill_block(tests[t].kind, nwords);
      for (int w = 0; w < nwords; w++) begin
        load_word(block_words[w]);
      end
      exp = expected_result(tests[t].cfg, nwords);
      run_block(tests[t].cfg, got);
      assert (got === exp) else begin
        $display("MISMATCH test %0d o_result expected %h got %h", t, exp, got);
        error_count++;
      end
      test_errors = error_count + assertion_failures() - errors_before;
      if (test_errors != 0) begin
        fail_count++;
      end
      if (tests[t].cfg.mode == EST_REAL) begin
        mode_name = "real";
      end else begin
        mode_name = "complex";
      end
      $display("test %0d: %s mode, %0d words, result %h, %s", t,
               mode_name, nwords, got, (test_errors == 0) ? "pass" : "FAIL");
    end

    total_errors = error_count + assertion_failures();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, NUM_TESTS - fail_count, fail_count, total_errors);
    if (total_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* dv/dcest_assert.sv */
module dcest_assert (
  input logic clk,
  input logic rst_n,
  input logic i_ld_req,
  input logic i_ld_ack,
  input logic i_rd_req,
  input logic i_rd_ack,
  input logic i_pulse
);

  // failed assertion count
  int fail_count = 0;

  ld_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(i_ld_ack) |-> i_ld_req) else begin
    $error("loader ack rose without a request");
    fail_count++;
  end

  rd_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(i_rd_ack) |-> i_rd_req) else begin
    $error("reader ack rose without a request");
    fail_count++;
  end

  // ack holds while its request is up
  ld_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (i_ld_ack && i_ld_req) |=> i_ld_ack) else begin
    $error("loader ack dropped early");
    fail_count++;
  end

  rd_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (i_rd_ack && i_rd_req) |=> i_rd_ack) else begin
    $error("reader ack dropped early");
    fail_count++;
  end

  // ack falls one cycle after its request
  ld_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(i_ld_req) |=> !i_ld_ack) else begin
    $error("loader ack stayed high after the request fell");
    fail_count++;
  end

  rd_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(i_rd_req) |=> !i_rd_ack) else begin
    $error("reader ack stayed high after the request fell");
    fail_count++;
  end

  pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
    i_pulse |=> !i_pulse) else begin
    $error("result valid longer than one cycle");
    fail_count++;
  end

endmodule

bind ram_arbiter dcest_assert u_arb_assert (
  .clk(clk), .rst_n(rst_n), .i_ld_req(i_ld_req), .i_ld_ack(o_ld_ack),
  .i_rd_req(i_rd_req), .i_rd_ack(o_rd_ack), .i_pulse(1'b0)
);

bind dc_estimator dcest_assert u_est_assert (
  .clk(clk), .rst_n(rst_n), .i_ld_req(1'b0), .i_ld_ack(1'b0),
  .i_rd_req(1'b0), .i_rd_ack(1'b0), .i_pulse(o_result_valid)
);

/* src/dcest_top.sv */
module dcest_top
  import dcest_cfg_pkg::*;
  import dcest_data_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_ld_req,
  input  ram_word_t  i_ld_word,
  output logic       o_ld_ack,
  input  logic       i_run_req,
  input  dcest_cfg_t i_cfg,
  output logic       o_run_ack,
  output result_t    o_result
);

  // loader side of the arbiter
  logic      ld_mem_req;
  mem_req_t  ld_mem;
  logic      ld_mem_ack;

  // reader side of the arbiter
  logic      rd_mem_req;
  mem_req_t  rd_mem;
  logic      rd_mem_ack;
  ram_word_t rd_data;

  // buffer port
  mem_req_t  mem;
  logic      mem_en;
  ram_word_t mem_rdata;

  // reader to estimator
  logic      start;
  logic      word_valid;
  ram_word_t word;
  logic      word_last;
  est_mode_t mode;
  scale_t    scale;
  result_t   est_result;
  logic      est_result_valid;

  sample_loader u_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_host_req (i_ld_req),
    .i_host_word(i_ld_word),
    .o_host_ack (o_ld_ack),
    .i_restart  (start),
    .o_mem_req  (ld_mem_req),
    .o_mem      (ld_mem),
    .i_mem_ack  (ld_mem_ack)
  );

  frame_reader u_reader (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_run_req     (i_run_req),
    .i_cfg         (i_cfg),
    .o_run_ack     (o_run_ack),
    .o_result      (o_result),
    .o_start       (start),
    .o_mem_req     (rd_mem_req),
    .o_mem         (rd_mem),
    .i_mem_ack     (rd_mem_ack),
    .i_mem_rdata   (rd_data),
    .o_word_valid  (word_valid),
    .o_word        (word),
    .o_word_last   (word_last),
    .o_mode        (mode),
    .o_scale       (scale),
    .i_result      (est_result),
    .i_result_valid(est_result_valid)
  );

  ram_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ld_req   (ld_mem_req),
    .i_ld_mem   (ld_mem),
    .o_ld_ack   (ld_mem_ack),
    .i_rd_req   (rd_mem_req),
    .i_rd_mem   (rd_mem),
    .o_rd_ack   (rd_mem_ack),
    .o_rd_data  (rd_data),
    .o_mem      (mem),
    .o_mem_en   (mem_en),
    .i_mem_rdata(mem_rdata)
  );

  sample_ram u_ram (
    .clk    (clk),
    .i_req  (mem),
    .i_en   (mem_en),
    .o_rdata(mem_rdata)
  );

  dc_estimator u_estimator (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_word_valid  (word_valid),
    .i_word        (word),
    .i_word_last   (word_last),
    .i_mode        (mode),
    .i_scale       (scale),
    .o_result      (est_result),
    .o_result_valid(est_result_valid)
  );

endmodule

/* src/dc_estimator.sv */
module dc_estimator
  import dcest_cfg_pkg::*;
  import dcest_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_word_valid,
  input  ram_word_t i_word,
  input  logic      i_word_last,
  input  est_mode_t i_mode,
  input  scale_t    i_scale,
  output result_t   o_result,
  output logic      o_result_valid
);

  // four lanes need two guard bits
  logic signed [IQ_W+1:0] sum_i_d;
  logic signed [IQ_W+1:0] sum_q_d;
  logic signed [IQ_W+1:0] sum_i_q;
  logic signed [IQ_W+1:0] sum_q_q;
  logic                   v1_q;
  logic                   last1_q;

  acc_t acc_i_q;
  acc_t acc_q_q;
  acc_t base_i;
  acc_t base_q;
  logic last2_q;

  logic signed [SCALE_W:0]       scale_s;
  logic signed [ACC_W+SCALE_W:0] prod_i_q;
  logic signed [ACC_W+SCALE_W:0] prod_q_q;
  logic                          last3_q;

  logic signed [ACC_W+SCALE_W:0] sh_i;
  logic signed [ACC_W+SCALE_W:0] sh_q;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, lane sums per word
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sum_i_d = '0;
    sum_q_d = '0;
    for (int k = 0; k < LANES; k++) begin
      if (k % 2 == 0) begin
        sum_i_d = sum_i_d + iq_t'(i_word[k*IQ_W +: IQ_W]);
      end else begin
        sum_q_d = sum_q_d + iq_t'(i_word[k*IQ_W +: IQ_W]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_word_valid) begin
      sum_i_q <= sum_i_d;
      sum_q_q <= sum_q_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, block accumulation
  ////////////////////////////////////////////////////////////////////////////

  // start over once stage 3 has taken the finished sums
  assign base_i = last2_q ? '0 : acc_i_q;
  assign base_q = last2_q ? '0 : acc_q_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1_q    <= 1'b0;
      last1_q <= 1'b0;
      last2_q <= 1'b0;
      last3_q <= 1'b0;
      acc_i_q <= '0;
      acc_q_q <= '0;
    end else begin
      v1_q    <= i_word_valid;
      last1_q <= i_word_valid & i_word_last;
      last2_q <= last1_q;
      last3_q <= last2_q;
      if (!v1_q) begin
        acc_i_q <= base_i;
        acc_q_q <= base_q;
      end else if (i_mode == EST_COMPLEX) begin
        acc_i_q <= base_i + acc_t'(sum_i_q);
        acc_q_q <= base_q + acc_t'(sum_q_q);
      end else begin
        // real mode keeps one total in the I accumulator
        acc_i_q <= base_i + acc_t'(sum_i_q) + acc_t'(sum_q_q);
        acc_q_q <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 3 and 4, scale then shift and pack
  ////////////////////////////////////////////////////////////////////////////

  // unsigned gain, zero extended into a signed operand
  assign scale_s = {1'b0, i_scale};

  always_ff @(posedge clk) begin
    prod_i_q <= acc_i_q * scale_s;
    prod_q_q <= acc_q_q * scale_s;
  end

  assign sh_i = prod_i_q >>> (SCALE_SHIFT + OUT_SHIFT);
  assign sh_q = prod_q_q >>> (SCALE_SHIFT + OUT_SHIFT);

  always_ff @(posedge clk) begin
    if (last3_q) begin
      if (i_mode == EST_COMPLEX) begin
        o_result <= {sh_q[ACC_W+SCALE_W], sh_q[IQ_W-2:0],
                     sh_i[ACC_W+SCALE_W], sh_i[IQ_W-2:0]};
      end else begin
        o_result <= sh_i[RES_W-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_result_valid <= 1'b0;
    end else begin
      o_result_valid <= last3_q;
    end
  end

endmodule

/* src/frame_reader.sv */
module frame_reader
  import dcest_cfg_pkg::*;
  import dcest_data_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_run_req,
  input  dcest_cfg_t i_cfg,
  output logic       o_run_ack,
  output result_t    o_result,
  output logic       o_start,
  output logic       o_mem_req,
  output mem_req_t   o_mem,
  input  logic       i_mem_ack,
  input  ram_word_t  i_mem_rdata,
  output logic       o_word_valid,
  output ram_word_t  o_word,
  output logic       o_word_last,
  output est_mode_t  o_mode,
  output scale_t     o_scale,
  input  result_t    i_result,
  input  logic       i_result_valid
);

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_FETCH,
    RD_RELEASE,
    RD_WAIT,
    RD_ACK
  } rd_state_t;

  rd_state_t  state_q;
  rd_state_t  state_d;
  dcest_cfg_t cfg_q;
  smp_cnt_t   smp_q;
  chp_cnt_t   chp_q;
  addr_t      addr_q;
  logic       done_q;
  logic       at_last;
  logic       take;

  // both counters at their limits marks the final word of the block
  assign at_last = (smp_q == cfg_q.smp_cnt) & (chp_q == cfg_q.chp_cnt);
  assign take    = (state_q == RD_FETCH) & i_mem_ack;

  assign o_start   = (state_q == RD_IDLE) & i_run_req;
  assign o_mem_req = (state_q == RD_FETCH);
  assign o_mem     = mem_req_t'{we: 1'b0, addr: addr_q, wdata: '0};
  assign o_run_ack = (state_q == RD_ACK);
  assign o_mode    = cfg_q.mode;
  assign o_scale   = cfg_q.scale;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (i_run_req) begin
          state_d = RD_FETCH;
        end
      end
      RD_FETCH: begin
        if (i_mem_ack) begin
          state_d = RD_RELEASE;
        end
      end
      RD_RELEASE: begin
        if (!i_mem_ack) begin
          state_d = done_q ? RD_WAIT : RD_FETCH;
        end
      end
      RD_WAIT: begin
        if (i_result_valid) begin
          state_d = RD_ACK;
        end
      end
      default: begin
        if (!i_run_req) begin
          state_d = RD_IDLE;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // sample and chirp counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= RD_IDLE;
      cfg_q        <= '0;
      smp_q        <= '0;
      chp_q        <= '0;
      addr_q       <= '0;
      done_q       <= 1'b0;
      o_word_valid <= 1'b0;
      o_word_last  <= 1'b0;
    end else begin
      state_q      <= state_d;
      o_word_valid <= take;
      o_word_last  <= take & at_last;
      if (o_start) begin
        cfg_q  <= i_cfg;
        smp_q  <= '0;
        chp_q  <= '0;
        addr_q <= '0;
        done_q <= 1'b0;
      end else if (take) begin
        addr_q <= addr_q + 1'b1;
        done_q <= at_last;
        // chirp steps when the sample count wraps
        if (smp_q == cfg_q.smp_cnt) begin
          smp_q <= '0;
          chp_q <= chp_q + 1'b1;
        end else begin
          smp_q <= smp_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      o_word <= i_mem_rdata;
    end
    if ((state_q == RD_WAIT) && i_result_valid) begin
      o_result <= i_result;
    end
  end

endmodule

/* src/sample_loader.sv */
module sample_loader
  import dcest_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_host_req,
  input  ram_word_t i_host_word,
  output logic      o_host_ack,
  input  logic      i_restart,
  output logic      o_mem_req,
  output mem_req_t  o_mem,
  input  logic      i_mem_ack
);

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_WRITE,
    LD_DONE,
    LD_RELEASE
  } ld_state_t;

  ld_state_t state_q;
  ld_state_t state_d;
  addr_t     wptr_q;

  // host word goes straight to the buffer at the write pointer
  assign o_mem      = mem_req_t'{we: 1'b1, addr: wptr_q, wdata: i_host_word};
  assign o_mem_req  = (state_q == LD_WRITE);
  assign o_host_ack = (state_q == LD_RELEASE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE: begin
        if (i_host_req) begin
          state_d = LD_WRITE;
        end
      end
      LD_WRITE: begin
        if (i_mem_ack) begin
          state_d = LD_DONE;
        end
      end
      // buffer handshake must finish before the host sees an ack
      LD_DONE: begin
        if (!i_mem_ack) begin
          state_d = LD_RELEASE;
        end
      end
      default: begin
        if (!i_host_req) begin
          state_d = LD_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LD_IDLE;
      wptr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (i_restart) begin
        wptr_q <= '0;
      end else if ((state_q == LD_DONE) && !i_mem_ack) begin
        wptr_q <= wptr_q + 1'b1;
      end
    end
  end

endmodule

/* src/ram_arbiter.sv */
module ram_arbiter
  import dcest_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_ld_req,
  input  mem_req_t  i_ld_mem,
  output logic      o_ld_ack,
  input  logic      i_rd_req,
  input  mem_req_t  i_rd_mem,
  output logic      o_rd_ack,
  output ram_word_t o_rd_data,
  output mem_req_t  o_mem,
  output logic      o_mem_en,
  input  ram_word_t i_mem_rdata
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACCESS,
    ARB_ACK,
    ARB_RELEASE
  } arb_state_t;

  arb_state_t state_q;
  arb_state_t state_d;
  logic       last_rd_q;
  logic       pick_rd;
  logic       gnt_req;
  logic       ack_on;
  ram_word_t  rd_data_q;

  // on a tie the client not served last wins
  assign pick_rd = i_rd_req & (~i_ld_req | ~last_rd_q);

  // request of the client holding the grant
  assign gnt_req = last_rd_q ? i_rd_req : i_ld_req;

  ////////////////////////////////////////////////////////////////////////////
  // buffer port, driven on the grant cycle only
  ////////////////////////////////////////////////////////////////////////////

  assign o_mem_en = (state_q == ARB_IDLE) & (i_ld_req | i_rd_req);
  assign o_mem    = pick_rd ? i_rd_mem : i_ld_mem;

  // acks go up with the read data and stay up until the request drops
  assign ack_on   = (state_q == ARB_ACCESS) | (state_q == ARB_ACK);
  assign o_ld_ack = ack_on & ~last_rd_q;
  assign o_rd_ack = ack_on & last_rd_q;

  assign o_rd_data = (state_q == ARB_ACCESS) ? i_mem_rdata : rd_data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (i_ld_req | i_rd_req) begin
          state_d = ARB_ACCESS;
        end
      end
      ARB_ACCESS: begin
        state_d = ARB_ACK;
      end
      ARB_ACK: begin
        if (!gnt_req) begin
          state_d = ARB_RELEASE;
        end
      end
      default: begin
        state_d = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ARB_IDLE;
      last_rd_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (o_mem_en) begin
        last_rd_q <= pick_rd;
      end
    end
  end

  // hold the word for the rest of the ack phase
  always_ff @(posedge clk) begin
    if (state_q == ARB_ACCESS) begin
      rd_data_q <= i_mem_rdata;
    end
  end

endmodule

/* src/sample_ram.sv */
module sample_ram
  import dcest_data_pkg::*;
(
  input  logic      clk,
  input  mem_req_t  i_req,
  input  logic      i_en,
  output ram_word_t o_rdata
);

  ram_word_t mem [2**ADDR_W];

  // single port, read returns the old contents on a write
  always_ff @(posedge clk) begin
    if (i_en) begin
      if (i_req.we) begin
        mem[i_req.addr] <= i_req.wdata;
      end
      o_rdata <= mem[i_req.addr];
    end
  end

  // read data stays put until the next enabled access

endmodule

/* src/dcest_data_pkg.sv */
package dcest_data_pkg;

  localparam int IQ_W   = 16;
  localparam int LANES  = 8;
  localparam int WORD_W = IQ_W * LANES;
  localparam int ADDR_W = 8;
  localparam int ACC_W  = 40;
  localparam int RES_W  = 32;

  // one signed lane, even lanes carry I and odd lanes carry Q
  typedef logic signed [IQ_W-1:0] iq_t;

  // buffer word, lane k at bits 16k+15 down to 16k
  typedef logic [WORD_W-1:0] ram_word_t;

  // 256 words cover the largest block of 16 x 16
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  typedef logic [RES_W-1:0] result_t;

  // one buffer access as seen by the arbiter
  typedef struct packed {
    logic      we;
    addr_t     addr;
    ram_word_t wdata;
  } mem_req_t;

endpackage

/* src/dcest_cfg_pkg.sv */
package dcest_cfg_pkg;

  // block limits, counted as size minus one
  localparam int SMP_W       = 4;
  localparam int CHP_W       = 4;

  // gain and output scaling
  localparam int SCALE_W     = 17;
  localparam int SCALE_SHIFT = 16;
  localparam int OUT_SHIFT   = 8;

  typedef logic [SMP_W-1:0]   smp_cnt_t;
  typedef logic [CHP_W-1:0]   chp_cnt_t;
  typedef logic [SCALE_W-1:0] scale_t;

  typedef enum logic {
    EST_COMPLEX = 1'b0,
    EST_REAL    = 1'b1
  } est_mode_t;

  // run configuration, latched by the reader at run start
  typedef struct packed {
    est_mode_t mode;
    smp_cnt_t  smp_cnt;
    chp_cnt_t  chp_cnt;
    scale_t    scale;
  } dcest_cfg_t;

endpackage
